// ==== matmul_top.f ====
logic/systolic_pkg.sv
logic/operand_buffer.sv
logic/operand_skew.sv
logic/mac_cell.sv
logic/mac_array.sv
logic/result_drain.sv
logic/matmul_ctrl.sv
logic/matmul_top.sv
verification/matmul_properties.sv
verification/matmul_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module matmul_tb \
    -Mdir obj_dir -o matmul_sim -f matmul_top.f

output=$(./obj_dir/matmul_sim +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'all tests passed'; then
    exit 0
fi
exit 1

// ==== verification/matmul_tb.sv ====
`timescale 1ns/10ps

module matmul_tb;
    import systolic_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_JOBS   = 8;
    // k of every job started below in order
    localparam int JOB_K [NUM_JOBS] = '{4, 1, 16, 16, 8, 6, 5, 3};

    logic               clk = 1'b0;
    logic               reset_n;
    logic               start_i;
    logic [K_WIDTH-1:0] k_i;
    logic               a_valid_i;
    a_col_t             a_data_i;
    logic               a_ready_o;
    logic               b_valid_i;
    b_row_t             b_data_i;
    logic               b_ready_o;
    logic               c_valid_o;
    result_beat_t       c_data_o;
    logic               c_ready_i;
    logic               busy_o;
    logic               done_o;

    elem_t a_mat [ARRAY_HEIGHT][MAX_K];
    elem_t b_mat [MAX_K][ARRAY_WIDTH];
    int    job_k;
    string test_name;
    bit    bp_random = 1'b0;

    // written only by the compare process
    int beat_cnt      = 0;
    int done_cnt      = 0;
    int beats_at_done = 0;
    int check_errs    = 0;

    // written only by the main sequence
    int main_errs     = 0;
    int errs_at_start = 0;
    int tests_run     = 0;
    int tests_bad     = 0;

    matmul_top i_dut (.*);

    bind matmul_top matmul_properties i_props (
        .clk       ( clk       ),
        .reset_n   ( reset_n   ),
        .c_valid_o ( c_valid_o ),
        .c_ready_i ( c_ready_i ),
        .c_data_o  ( c_data_o  ),
        .a_ready_o ( a_ready_o ),
        .b_ready_o ( b_ready_o ),
        .busy_o    ( busy_o    ),
        .done_o    ( done_o    )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // sum over k of A[r][k]*B[k][c] kept to 16 bits
    function automatic acc_t ref_elem(input int r, input int c, input int k);
        int sum;
        sum = 0;
        for (int i = 0; i < k; i++) begin
            sum += int'(a_mat[r][i]) * int'(b_mat[i][c]);
        end
        return acc_t'(sum);
    endfunction

    function automatic a_col_t a_column(input int i);
        a_col_t col;
        for (int r = 0; r < ARRAY_HEIGHT; r++) begin
            col[r] = a_mat[r][i];
        end
        return col;
    endfunction

    function automatic b_row_t b_row(input int i);
        b_row_t row;
        for (int c = 0; c < ARRAY_WIDTH; c++) begin
            row[c] = b_mat[i][c];
        end
        return row;
    endfunction

    always @(negedge clk) begin : compare
        int   row;
        acc_t expected;
        if (reset_n && c_valid_o && c_ready_i) begin
            row = beat_cnt % ARRAY_HEIGHT;
            assert (c_data_o.row == ROW_WIDTH'(row)) else begin
                $display("MISMATCH %s row index: expected %0d, actual %0d",
                         test_name, row, c_data_o.row);
                check_errs++;
            end
            for (int c = 0; c < ARRAY_WIDTH; c++) begin
                expected = ref_elem(row, c, job_k);
                assert (c_data_o.data[c] == expected) else begin
                    $display("MISMATCH %s C[%0d][%0d]: expected %h, actual %h",
                             test_name, row, c, expected, c_data_o.data[c]);
                    check_errs++;
                end
            end
            beat_cnt++;
        end
        if (reset_n && done_o) begin
            done_cnt++;
            assert (beat_cnt - beats_at_done == ARRAY_HEIGHT) else begin
                $display("MISMATCH %s beats before done_o: expected %0d, actual %0d",
                         test_name, ARRAY_HEIGHT, beat_cnt - beats_at_done);
                check_errs++;
            end
            beats_at_done = beat_cnt;
        end
    end

    // result ready is random while back-pressure is on
    initial begin
        c_ready_i = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            c_ready_i = bp_random ? 1'($urandom) : 1'b1;
        end
    end

    initial begin : watchdog
        int budget_ns;
        budget_ns = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            budget_ns += (2 * JOB_K[j] + 12 + ARRAY_HEIGHT) * CLK_PERIOD;
        end
        budget_ns *= 4;
        #(budget_ns);
        $display("watchdog: jobs did not complete within %0d ns", budget_ns);
        $display("tests failed");
        $finish;
    end

    task automatic fill_operands(input int k, input bit all_ones);
        for (int i = 0; i < k; i++) begin
            for (int r = 0; r < ARRAY_HEIGHT; r++) begin
                a_mat[r][i] = all_ones ? 8'hff : elem_t'($urandom);
            end
            for (int c = 0; c < ARRAY_WIDTH; c++) begin
                b_mat[i][c] = all_ones ? 8'hff : elem_t'($urandom);
            end
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic send_a(input int k, input bit gaps);
        int i;
        bit hs;
        i = 0;
        while (i < k) begin
            a_valid_i = !(gaps && (($urandom % 3) == 0));
            a_data_i  = a_column(i);
            @(negedge clk);
            hs = a_valid_i && a_ready_o;
            @(posedge clk);
            #1;
            if (hs) begin
                i++;
            end
        end
        a_valid_i = 1'b0;
    endtask

    task automatic send_b(input int k, input bit gaps);
        int i;
        bit hs;
        i = 0;
        while (i < k) begin
            b_valid_i = !(gaps && (($urandom % 3) == 0));
            b_data_i  = b_row(i);
            @(negedge clk);
            hs = b_valid_i && b_ready_o;
            @(posedge clk);
            #1;
            if (hs) begin
                i++;
            end
        end
        b_valid_i = 1'b0;
    endtask

    // a start with a different k while the job is loading
    task automatic pulse_while_busy(input bit enable);
        if (enable) begin
            repeat (2) @(posedge clk);
            #1;
            start_i = 1'b1;
            k_i     = K_WIDTH'(1);
            @(posedge clk);
            #1;
            start_i = 1'b0;
        end
    endtask

    task automatic run_job(input int k_field, input int k_eff, input bit gaps,
                           input bit spur);
        int beats_before;
        int done_before;
        beats_before = beat_cnt;
        done_before  = done_cnt;
        job_k        = k_eff;
        @(posedge clk);
        #1;
        start_i = 1'b1;
        k_i     = K_WIDTH'(k_field);
        @(posedge clk);
        #1;
        start_i = 1'b0;
        fork
            send_a(k_eff, gaps);
            send_b(k_eff, gaps);
            pulse_while_busy(spur);
        join
        do begin
            @(negedge clk);
        end while (!done_o);
        assert (!busy_o) else begin
            $display("%s: busy_o still high while done_o pulses", test_name);
            main_errs++;
        end
        repeat (3) @(posedge clk);
        assert (beat_cnt - beats_before == ARRAY_HEIGHT) else begin
            $display("MISMATCH %s result beats: expected %0d, actual %0d",
                     test_name, ARRAY_HEIGHT, beat_cnt - beats_before);
            main_errs++;
        end
        assert (done_cnt - done_before == 1) else begin
            $display("MISMATCH %s done pulses: expected 1, actual %0d",
                     test_name, done_cnt - done_before);
            main_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errs_at_start = main_errs + check_errs;
    endtask

    task automatic end_test();
        int n;
        n = main_errs + check_errs - errs_at_start;
        $display("%-16s %s, %0d errors", test_name, (n == 0) ? "ok" : "bad", n);
        tests_run++;
        if (n != 0) begin
            tests_bad++;
        end
    endtask

    initial begin : main
        int prop_fails;
        void'($urandom(32'hd1f3e245));
        reset_n   = 1'b0;
        start_i   = 1'b0;
        k_i       = '0;
        a_valid_i = 1'b0;
        a_data_i  = '0;
        b_valid_i = 1'b0;
        b_data_i  = '0;
        job_k     = 0;
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        begin_test("reset_idle");
        @(negedge clk);
        assert (!c_valid_o && !a_ready_o && !b_ready_o && !busy_o && !done_o) else begin
            $display("%s: outputs not idle after reset", test_name);
            main_errs++;
        end
        end_test();

        begin_test("random_multiply");
        fill_operands(4, 1'b0);
        run_job(4, 4, 1'b0, 1'b0);
        end_test();

        // k_i of 0 stands for MAX_K
        begin_test("edge_sizes");
        fill_operands(1, 1'b0);
        run_job(1, 1, 1'b0, 1'b0);
        fill_operands(MAX_K, 1'b0);
        run_job(0, MAX_K, 1'b0, 1'b0);
        fill_operands(MAX_K, 1'b1);
        run_job(MAX_K, MAX_K, 1'b0, 1'b0);
        end_test();

        begin_test("input_gaps");
        fill_operands(8, 1'b0);
        run_job(8, 8, 1'b1, 1'b0);
        end_test();

        begin_test("back_pressure");
        bp_random = 1'b1;
        fill_operands(6, 1'b0);
        run_job(6, 6, 1'b0, 1'b0);
        bp_random = 1'b0;
        end_test();

        begin_test("back_to_back");
        fill_operands(5, 1'b0);
        run_job(5, 5, 1'b0, 1'b1);
        fill_operands(3, 1'b0);
        run_job(3, 3, 1'b0, 1'b0);
        end_test();

        prop_fails = i_dut.i_props.fail_hold + i_dut.i_props.fail_idle
                   + i_dut.i_props.fail_done;
        $display("summary: %0d tests run, %0d with errors, %0d beats checked, %0d property errors",
                 tests_run, tests_bad, beat_cnt, prop_fails);
        if (main_errs + check_errs + prop_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verification/matmul_properties.sv ====
`timescale 1ns/10ps

module matmul_properties (
    input logic                       clk,
    input logic                       reset_n,
    input logic                       c_valid_o,
    input logic                       c_ready_i,
    input systolic_pkg::result_beat_t c_data_o,
    input logic                       a_ready_o,
    input logic                       b_ready_o,
    input logic                       busy_o,
    input logic                       done_o
);

    int fail_hold = 0;
    int fail_idle = 0;
    int fail_done = 0;

    // a stalled beat stays put
    assert property (@(posedge clk) disable iff (!reset_n)
        c_valid_o && !c_ready_i |=> c_valid_o && $stable(c_data_o))
    else begin
        $error("c_valid_o dropped or c_data_o changed before the beat was taken");
        fail_hold++;
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        !busy_o |-> !a_ready_o && !b_ready_o)
    else begin
        $error("operand ready high while the engine is idle");
        fail_idle++;
    end

    // done follows the last result handshake
    assert property (@(posedge clk) disable iff (!reset_n)
        done_o |-> $past(c_valid_o && c_ready_i))
    else begin
        $error("done_o high without a result handshake in the cycle before");
        fail_done++;
    end

endmodule

// ==== logic/matmul_top.sv ====
`timescale 1ns/10ps

module matmul_top (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              start_i,
    input  logic [systolic_pkg::K_WIDTH-1:0]  k_i,
    input  logic                              a_valid_i,
    input  systolic_pkg::a_col_t              a_data_i,
    output logic                              a_ready_o,
    input  logic                              b_valid_i,
    input  systolic_pkg::b_row_t              b_data_i,
    output logic                              b_ready_o,
    output logic                              c_valid_o,
    output systolic_pkg::result_beat_t        c_data_o,
    input  logic                              c_ready_i,
    output logic                              busy_o,
    output logic                              done_o
);
    import systolic_pkg::*;

    logic [K_WIDTH-1:0]        k_job;
    logic                      load_en, replay_en, clear, capture;
    logic                      a_full, b_full, drain_done;
    logic                      a_rep_valid, b_rep_valid;
    a_col_t                    a_rep, a_skew_in, a_skew_out;
    b_row_t                    b_rep, b_skew_in, b_skew_out;
    c_row_t [ARRAY_HEIGHT-1:0] acc_grid;

    matmul_ctrl i_ctrl (
        .clk, .reset_n, .start_i, .k_i,
        .a_full_i     ( a_full     ),
        .b_full_i     ( b_full     ),
        .drain_done_i ( drain_done ),
        .k_o          ( k_job      ),
        .load_en_o    ( load_en    ),
        .replay_en_o  ( replay_en  ),
        .clear_o      ( clear      ),
        .capture_o    ( capture    ),
        .busy_o, .done_o
    );

    operand_buffer #(.payload_t(a_col_t)) i_a_buf (
        .clk, .reset_n,
        .load_en_i ( load_en ), .replay_en_i ( replay_en ), .k_i ( k_job ),
        .valid_i ( a_valid_i ), .data_i ( a_data_i ), .ready_o ( a_ready_o ),
        .full_o ( a_full ), .data_o ( a_rep ), .data_valid_o ( a_rep_valid )
    );

    operand_buffer #(.payload_t(b_row_t)) i_b_buf (
        .clk, .reset_n,
        .load_en_i ( load_en ), .replay_en_i ( replay_en ), .k_i ( k_job ),
        .valid_i ( b_valid_i ), .data_i ( b_data_i ), .ready_o ( b_ready_o ),
        .full_o ( b_full ), .data_o ( b_rep ), .data_valid_o ( b_rep_valid )
    );

    // idle cycles enter the array as zeros
    assign a_skew_in = a_rep_valid ? a_rep : '0;
    assign b_skew_in = b_rep_valid ? b_rep : '0;

    operand_skew #(.LANES(ARRAY_HEIGHT)) i_a_skew (
        .clk, .reset_n, .lanes_i ( a_skew_in ), .lanes_o ( a_skew_out )
    );

    operand_skew #(.LANES(ARRAY_WIDTH)) i_b_skew (
        .clk, .reset_n, .lanes_i ( b_skew_in ), .lanes_o ( b_skew_out )
    );

    mac_array i_array (
        .clk, .reset_n, .clear_i ( clear ),
        .a_col_i ( a_skew_out ), .b_row_i ( b_skew_out ), .acc_o ( acc_grid )
    );

    result_drain i_drain (
        .clk, .reset_n, .capture_i ( capture ), .acc_i ( acc_grid ),
        .c_valid_o, .c_data_o, .c_ready_i, .drain_done_o ( drain_done )
    );

endmodule

// ==== logic/matmul_ctrl.sv ====
`timescale 1ns/10ps

module matmul_ctrl (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             start_i,
    input  logic [systolic_pkg::K_WIDTH-1:0] k_i,
    input  logic                             a_full_i,
    input  logic                             b_full_i,
    input  logic                             drain_done_i,
    output logic [systolic_pkg::K_WIDTH-1:0] k_o,
    output logic                             load_en_o,
    output logic                             replay_en_o,
    output logic                             clear_o,
    output logic                             capture_o,
    output logic                             busy_o,
    output logic                             done_o
);
    import systolic_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_COMPUTE,
        ST_DRAIN
    } state_t;

    state_t             state;
    logic [K_WIDTH-1:0] k_q;
    logic [K_WIDTH:0]   cycle_cnt;
    logic [K_WIDTH:0]   last_cycle;

    // replay, skew depth and array pass-through
    assign last_cycle = {1'b0, k_q} + (K_WIDTH + 1)'(ARRAY_HEIGHT + ARRAY_WIDTH - 1);

    assign k_o         = k_q;
    assign busy_o      = (state != ST_IDLE);
    assign load_en_o   = (state == ST_LOAD);
    assign replay_en_o = (state == ST_COMPUTE) && (cycle_cnt < {1'b0, k_q});
    assign clear_o     = (state == ST_COMPUTE) && (cycle_cnt == '0);
    assign capture_o   = (state == ST_COMPUTE) && (cycle_cnt == last_cycle);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= ST_IDLE;
            k_q       <= '0;
            cycle_cnt <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        // zero means the largest job
                        k_q   <= (k_i == '0) ? K_WIDTH'(MAX_K) : k_i;
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    if (a_full_i && b_full_i) begin
                        cycle_cnt <= '0;
                        state     <= ST_COMPUTE;
                    end
                end
                ST_COMPUTE: begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                    if (cycle_cnt == last_cycle) begin
                        state <= ST_DRAIN;
                    end
                end
                default: begin
                    if (drain_done_i) begin
                        done_o <= 1'b1;
                        state  <= ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== logic/result_drain.sv ====
`timescale 1ns/10ps

module result_drain (
    input  logic                                                clk,
    input  logic                                                reset_n,
    input  logic                                                capture_i,
    input  systolic_pkg::c_row_t [systolic_pkg::ARRAY_HEIGHT-1:0] acc_i,
    output logic                                                c_valid_o,
    output systolic_pkg::result_beat_t                          c_data_o,
    input  logic                                                c_ready_i,
    output logic                                                drain_done_o
);
    import systolic_pkg::*;

    c_row_t [ARRAY_HEIGHT-1:0] grid_q;
    logic [ROW_WIDTH-1:0]      row_q;
    logic                      last_row;
    logic                      beat_taken;

    assign beat_taken   = c_valid_o && c_ready_i;
    assign last_row     = (row_q == ROW_WIDTH'(ARRAY_HEIGHT - 1));
    assign drain_done_o = beat_taken && last_row;

    // beat is a pure function of the snapshot and row, so it holds under stall
    assign c_data_o.row  = row_q;
    assign c_data_o.data = grid_q[row_q];

    always_ff @(posedge clk) begin
        if (capture_i) begin
            grid_q <= acc_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            c_valid_o <= 1'b0;
            row_q     <= '0;
        end else if (capture_i) begin
            c_valid_o <= 1'b1;
            row_q     <= '0;
        end else if (beat_taken) begin
            if (last_row) begin
                c_valid_o <= 1'b0;
            end
            row_q <= row_q + 1'b1;
        end
    end

endmodule

// ==== logic/mac_array.sv ====
`timescale 1ns/10ps

module mac_array (
    input  logic                                                clk,
    input  logic                                                reset_n,
    input  logic                                                clear_i,
    input  systolic_pkg::a_col_t                                a_col_i,
    input  systolic_pkg::b_row_t                                b_row_i,
    output systolic_pkg::c_row_t [systolic_pkg::ARRAY_HEIGHT-1:0] acc_o
);
    import systolic_pkg::*;

    // a runs along rows, b runs down columns
    elem_t a_h [ARRAY_HEIGHT][ARRAY_WIDTH+1];
    elem_t b_v [ARRAY_HEIGHT+1][ARRAY_WIDTH];

    for (genvar r = 0; r < ARRAY_HEIGHT; r++) begin : g_a_edge
        assign a_h[r][0] = a_col_i[r];
    end

    for (genvar c = 0; c < ARRAY_WIDTH; c++) begin : g_b_edge
        assign b_v[0][c] = b_row_i[c];
    end

    for (genvar r = 0; r < ARRAY_HEIGHT; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_WIDTH; c++) begin : g_col
            mac_cell i_cell (
                .clk     ( clk          ),
                .reset_n ( reset_n      ),
                .clear_i ( clear_i      ),
                .a_i     ( a_h[r][c]    ),
                .b_i     ( b_v[r][c]    ),
                .a_o     ( a_h[r][c+1]  ),
                .b_o     ( b_v[r+1][c]  ),
                .acc_o   ( acc_o[r][c]  )
            );
        end
    end

endmodule

// ==== logic/mac_cell.sv ====
`timescale 1ns/10ps

module mac_cell (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                clear_i,
    input  systolic_pkg::elem_t a_i,
    input  systolic_pkg::elem_t b_i,
    output systolic_pkg::elem_t a_o,
    output systolic_pkg::elem_t b_o,
    output systolic_pkg::acc_t  acc_o
);
    import systolic_pkg::*;

    acc_t product;

    assign product = acc_t'(a_i) * acc_t'(b_i);

    // operands move one cell per cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_o <= '0;
            b_o <= '0;
        end else begin
            a_o <= a_i;
            b_o <= b_i;
        end
    end

    // wraps modulo 2^ACC_WIDTH
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc_o <= '0;
        end else if (clear_i) begin
            acc_o <= '0;
        end else begin
            acc_o <= acc_o + product;
        end
    end

endmodule

// ==== logic/operand_skew.sv ====
`timescale 1ns/10ps

module operand_skew #(
    parameter int LANES = 4
) (
    input  logic                              clk,
    input  logic                              reset_n,
    input  systolic_pkg::elem_t [LANES-1:0]   lanes_i,
    output systolic_pkg::elem_t [LANES-1:0]   lanes_o
);
    import systolic_pkg::*;

    // lane 0 goes straight through
    assign lanes_o[0] = lanes_i[0];

    for (genvar i = 1; i < LANES; i++) begin : g_lane
        elem_t [i-1:0] dly;

        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                dly <= '0;
            end else begin
                dly[0] <= lanes_i[i];
                for (int s = 1; s < i; s++) begin
                    dly[s] <= dly[s-1];
                end
            end
        end

        // i registers deep
        assign lanes_o[i] = dly[i-1];
    end

endmodule

// ==== logic/operand_buffer.sv ====
`timescale 1ns/10ps

module operand_buffer #(
    parameter type payload_t = systolic_pkg::elem_t
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            load_en_i,
    input  logic                            replay_en_i,
    input  logic [systolic_pkg::K_WIDTH-1:0] k_i,
    input  logic                            valid_i,
    input  payload_t                        data_i,
    output logic                            ready_o,
    output logic                            full_o,
    output payload_t                        data_o,
    output logic                            data_valid_o
);
    import systolic_pkg::*;

    payload_t              mem [MAX_K];
    logic [K_WIDTH-1:0]    wr_cnt;
    logic [ADDR_WIDTH-1:0] rd_ptr;

    assign ready_o = load_en_i && (wr_cnt != k_i);
    assign full_o  = load_en_i && (wr_cnt == k_i);

    always_ff @(posedge clk) begin
        if (valid_i && ready_o) begin
            mem[wr_cnt[ADDR_WIDTH-1:0]] <= data_i;
        end
    end

    // write count restarts whenever the load phase is left
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_cnt <= '0;
        end else if (!load_en_i) begin
            wr_cnt <= '0;
        end else if (valid_i && ready_o) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr       <= '0;
            data_valid_o <= 1'b0;
        end else begin
            data_valid_o <= replay_en_i;
            rd_ptr       <= replay_en_i ? rd_ptr + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (replay_en_i) begin
            data_o <= mem[rd_ptr];
        end
    end

endmodule

// ==== logic/systolic_pkg.sv ====
package systolic_pkg;

    // array geometry
    localparam int ARRAY_HEIGHT = 4;
    localparam int ARRAY_WIDTH  = 8;

    // accumulators are double the element width
    localparam int DATA_WIDTH   = 8;
    localparam int ACC_WIDTH    = 2 * DATA_WIDTH;

    // K field has to hold MAX_K itself
    localparam int MAX_K        = 16;
    localparam int K_WIDTH      = $clog2(MAX_K + 1);
    localparam int ADDR_WIDTH   = $clog2(MAX_K);
    localparam int ROW_WIDTH    = $clog2(ARRAY_HEIGHT);

    typedef logic [DATA_WIDTH-1:0] elem_t;
    typedef logic [ACC_WIDTH-1:0]  acc_t;

    // one A column and one B row per input beat
    typedef elem_t [ARRAY_HEIGHT-1:0] a_col_t;
    typedef elem_t [ARRAY_WIDTH-1:0]  b_row_t;

    typedef acc_t [ARRAY_WIDTH-1:0] c_row_t;

    // one row of C with its index
    typedef struct packed {
        logic [ROW_WIDTH-1:0] row;
        c_row_t               data;
    } result_beat_t;

endpackage
